// File: project.f
mcu_pkg.sv
code_rom.sv
xdata_ram.sv
iram.sv
cpu_core.sv
mcu_ice.sv
mcu_ice_assert.sv
tb_mcu_ice.sv

// File: Bender.yml
package:
  name: mcu_ice

sources:
  - mcu_pkg.sv
  - code_rom.sv
  - xdata_ram.sv
  - iram.sv
  - cpu_core.sv
  - mcu_ice.sv
  - target: simulation
    files:
      - mcu_ice_assert.sv
      - tb_mcu_ice.sv

// File: tb_mcu_ice.sv
`timescale 1ns/10ps

module tb_mcu_ice;

   import mcu_pkg::*;

   localparam int CLK_PERIOD   = 4;
   localparam int RESET_CYCLES = 8;
   localparam int NUM_TESTS    = 5;
   localparam int MAX_CHANGES  = 34;
   localparam int MAX_INSTR    = 400;
   localparam int MARGIN       = 200;
   localparam int SETTLE       = 40;
   // Writes x 6 instructions x 6 cycles, plus reset, load and margin
   localparam int TEST_CYCLES  = RESET_CYCLES + CODE_BYTES + MAX_CHANGES * 36 + MARGIN + SETTLE;
   localparam int WATCHDOG_NS  = NUM_TESTS * TEST_CYCLES * CLK_PERIOD;
   // Direct byte that no program ever writes
   localparam logic [7:0] ZERO_BYTE = 8'h08;

   logic       clk;
   logic       nrst;
   logic       run;
   logic       prog_we;
   logic [5:0] prog_addr;
   logic [7:0] prog_data;
   logic [4:0] led;

   logic [7:0] prog [0:CODE_BYTES-1];
   int         plen;
   logic [4:0] exp_q [$];
   string      test_name;
   bit         running;
   int         got;
   int         test_err;
   int         n_pass;
   int         n_fail;
   int         seed = 74;

   mcu_ice i_mcu_ice (
      .i_clk       (clk),
      .i_nrst      (nrst),
      .i_run       (run),
      .i_prog_we   (prog_we),
      .i_prog_addr (prog_addr),
      .i_prog_data (prog_data),
      .o_led       (led)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   ////////////////////////////////////////
   // Program building

   function automatic int rand_below(input int n);
      return $unsigned($random(seed)) % n;
   endfunction

   function automatic void emit(input logic [7:0] b);
      prog[plen] = b;
      plen++;
   endfunction

   function automatic void emit2(input logic [7:0] op, input logic [7:0] arg);
      emit(op);
      emit(arg);
   endfunction

   function automatic void emit_dptr(input logic [15:0] val);
      emit(OP_MOV_DPTR);
      emit(val[15:8]);
      emit(val[7:0]);
   endfunction

   function automatic void clear_prog();
      for (int i = 0; i < CODE_BYTES; i++) begin
         prog[i] = OP_NOP;
      end
      plen = 0;
   endfunction

   // Builds v in bit byte 0x20+k with SETB, then loads it into A
   function automatic void load_acc(input logic [4:0] v, input logic [3:0] k);
      for (int b = 0; b < 5; b++) begin
         if (v[b]) begin
            emit2(OP_SETB, {1'b0, k, 3'(b)});
         end
      end
      emit2(OP_MOV_A_DIR, 8'h20 + 8'(k));
   endfunction

   function automatic logic [7:0] unlisted_op(input int i);
      case (i)
         0:       return 8'h01;
         1:       return 8'h12;
         2:       return 8'h23;
         3:       return 8'h74;
         4:       return 8'h85;
         5:       return 8'hA5;
         6:       return 8'hB4;
         default: return 8'hFF;
      endcase
   endfunction

   ////////////////////////////////////////
   // Reference model

   // Only changes of byte 0 are visible on the LEDs
   function automatic void ref_model();
      logic [15:0] pc;
      logic [15:0] dptr;
      logic [7:0]  acc;
      logic [7:0]  op;
      logic [7:0]  b1;
      logic [7:0]  b2;
      logic [4:0]  led_m;
      logic [7:0]  iram_m [0:127];
      logic [7:0]  xram_m [0:15];
      pc = 0;
      dptr = 0;
      acc = 0;
      led_m = 0;
      exp_q.delete();
      for (int i = 0; i < 128; i++) begin
         iram_m[i] = 8'h00;
      end
      for (int i = 0; i < 16; i++) begin
         xram_m[i] = 8'h00;
      end
      for (int n = 0; n < MAX_INSTR && exp_q.size() < MAX_CHANGES; n++) begin
         op = prog[pc % CODE_BYTES];
         b1 = prog[(pc + 1) % CODE_BYTES];
         b2 = prog[(pc + 2) % CODE_BYTES];
         case (op)
            OP_INC_A: begin
               acc = acc + 8'd1;
               pc = pc + 1;
            end
            OP_MOV_DPTR: begin
               dptr = {b1, b2};
               pc = pc + 3;
            end
            OP_MOVX_WR: begin
               xram_m[dptr[3:0]] = acc;
               if (dptr[3:0] == 4'd0 && acc[4:0] != led_m) begin
                  led_m = acc[4:0];
                  exp_q.push_back(led_m);
               end
               pc = pc + 1;
            end
            OP_MOVX_RD: begin
               acc = xram_m[dptr[3:0]];
               pc = pc + 1;
            end
            OP_MOV_DIR_A: begin
               if (!b1[7]) begin
                  iram_m[b1[6:0]] = acc;
               end
               pc = pc + 2;
            end
            OP_MOV_A_DIR: begin
               acc = b1[7] ? 8'h00 : iram_m[b1[6:0]];
               pc = pc + 2;
            end
            OP_SETB, OP_CLR: begin
               if (!b1[7]) begin
                  iram_m[32 + b1[6:3]][b1[2:0]] = (op == OP_SETB);
               end
               pc = pc + 2;
            end
            OP_SJMP: begin
               pc = pc + 16'd2 + {{8{b1[7]}}, b1};
            end
            default: begin
               pc = pc + 1;
            end
         endcase
      end
   endfunction

   ////////////////////////////////////////
   // Compare and test sequencing

   always @(led) begin
      if (running) begin
         if (got >= exp_q.size()) begin
            $display("Error in %s: LEDs changed to %0d after the last expected value",
                     test_name, led);
            test_err++;
         end else begin
            if (led !== exp_q[got]) begin
               $display("** Error %s: expected %0d, actual %0d", test_name, exp_q[got], led);
               test_err++;
            end
            got++;
         end
      end
   end

   task automatic tick();
      @(posedge clk);
      #1;
   endtask

   task automatic run_test(input string name, input int settle);
      int cyc;
      test_name = name;
      test_err = 0;
      got = 0;
      ref_model();
      run = 1'b0;
      nrst = 1'b0;
      repeat (RESET_CYCLES) tick();
      nrst = 1'b1;
      if (led !== 5'd0) begin
         $display("** Error %s: expected %0d, actual %0d after reset", name, 0, led);
         test_err++;
      end
      for (int a = 0; a < CODE_BYTES; a++) begin
         prog_we = 1'b1;
         prog_addr = 6'(a);
         prog_data = prog[a];
         tick();
      end
      prog_we = 1'b0;
      if (led !== 5'd0) begin
         $display("** Error %s: expected %0d, actual %0d while idle", name, 0, led);
         test_err++;
      end
      running = 1'b1;
      run = 1'b1;
      cyc = 0;
      while (got < exp_q.size() && cyc < exp_q.size() * 36 + MARGIN) begin
         @(posedge clk);
         cyc++;
      end
      if (got < exp_q.size()) begin
         $display("Error in %s: only %0d of %0d LED changes were seen",
                  name, got, exp_q.size());
         test_err++;
      end
      repeat (settle) @(posedge clk);
      #1;
      run = 1'b0;
      running = 1'b0;
      $display("%-16s %s (%0d of %0d LED values)", name, (test_err == 0) ? "PASS" : "FAIL",
               got, exp_q.size());
      if (test_err == 0) begin
         n_pass++;
      end else begin
         n_fail++;
      end
   endtask

   initial begin
      #(WATCHDOG_NS);
      $display("Watchdog expired before all tests finished");
      $display("Test failed");
      $finish;
   end

   initial begin
      logic [4:0] r;
      logic [7:0] dir;
      logic [3:0] k;
      clk = 1'b0;
      nrst = 1'b0;
      run = 1'b0;
      prog_we = 1'b0;
      prog_addr = 6'd0;
      prog_data = 8'h00;

      // Counter loop, SJMP back 7 bytes to address 0
      clear_prog();
      emit(OP_INC_A);
      emit_dptr(16'h0000);
      emit(OP_MOVX_WR);
      emit2(OP_SJMP, 8'hF9);
      run_test("counter", 0);

      // Round trip through random direct bytes
      clear_prog();
      emit_dptr(16'h0000);
      r = 5'(rand_below(31) + 1);
      for (int i = 0; i < 2; i++) begin
         dir = 8'h30 + 8'(rand_below(8'h50));
         load_acc(r, 4'(i + 1));
         emit2(OP_MOV_DIR_A, dir);
         emit2(OP_MOV_A_DIR, ZERO_BYTE);
         emit2(OP_MOV_A_DIR, dir);
         emit(OP_MOVX_WR);
         r = r ^ (5'd1 << rand_below(5));
      end
      emit2(OP_SJMP, 8'hFE);
      run_test("iram_roundtrip", SETTLE);

      // Bit set and clear within one random byte
      clear_prog();
      k = 4'(rand_below(16));
      emit_dptr(16'h0000);
      for (int i = 0; i < 3; i++) begin
         for (int j = 0; j < 2; j++) begin
            emit2((i == 0 || rand_below(2) == 1) ? OP_SETB : OP_CLR,
                  {1'b0, k, 3'(rand_below(5))});
         end
         emit2(OP_MOV_A_DIR, 8'h20 + 8'(k));
         emit(OP_MOVX_WR);
      end
      emit2(OP_SJMP, 8'hFE);
      run_test("bit_ops", SETTLE);

      // Write to byte 5, read back, step once, show on byte 0
      clear_prog();
      r = 5'(rand_below(29) + 2);
      emit(OP_INC_A);
      emit_dptr(16'h0000);
      emit(OP_MOVX_WR);
      load_acc(r, 4'd0);
      emit_dptr(16'h0005);
      emit(OP_MOVX_WR);
      emit2(OP_MOV_A_DIR, ZERO_BYTE);
      emit(OP_MOVX_RD);
      emit(OP_INC_A);
      emit_dptr(16'h0000);
      emit(OP_MOVX_WR);
      emit2(OP_SJMP, 8'hFE);
      run_test("xdata_readback", SETTLE);

      clear_prog();
      for (int i = 0; i < 4; i++) begin
         emit(unlisted_op(rand_below(8)));
         emit(OP_INC_A);
         emit(unlisted_op(rand_below(8)));
      end
      emit_dptr(16'h0000);
      emit(OP_MOVX_WR);
      emit2(OP_SJMP, 8'hFE);
      run_test("unlisted_ops", SETTLE);

      $display("Summary: %0d tests passed, %0d failed", n_pass, n_fail);
      if (n_fail == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

// File: mcu_ice_assert.sv
`timescale 1ns/10ps

module mcu_ice_assert (
   input logic                i_clk,
   input logic                i_nrst,
   input logic                i_run,
   input mcu_pkg::code_req_t  i_code_req,
   input mcu_pkg::code_rsp_t  i_code_rsp,
   input mcu_pkg::xdata_req_t i_xdata_req,
   input mcu_pkg::xdata_rsp_t i_xdata_rsp
);

   ////////////////////////////////////////
   // Handshake timing

   code_ack_next: assert property (@(posedge i_clk) disable iff (!i_nrst)
      i_code_req.stb |=> i_code_rsp.ack)
      else $error("code strobe without acknowledge one cycle later");

   xdata_ack_next: assert property (@(posedge i_clk) disable iff (!i_nrst)
      i_xdata_req.stb |=> i_xdata_rsp.ack)
      else $error("xdata strobe without acknowledge one cycle later");

   // Strobe registers cleared while the core is held
   idle_no_stb: assert property (@(posedge i_clk) disable iff (!i_nrst)
      !i_run |=> !i_code_req.stb && !i_xdata_req.stb)
      else $error("strobe high in the cycle after run was low");

   ////////////////////////////////////////
   // Request stability

   code_req_stable: assert property (@(posedge i_clk) disable iff (!i_nrst || !i_run)
      i_code_req.stb && !i_code_rsp.ack |=> $stable(i_code_req))
      else $error("code request changed before acknowledge");

   xdata_req_stable: assert property (@(posedge i_clk) disable iff (!i_nrst || !i_run)
      i_xdata_req.stb && !i_xdata_rsp.ack |=> $stable(i_xdata_req))
      else $error("xdata request changed before acknowledge");

endmodule

bind cpu_core mcu_ice_assert u_mcu_ice_assert (
   .i_clk       (i_clk),
   .i_nrst      (i_nrst),
   .i_run       (i_run),
   .i_code_req  (o_code_req),
   .i_code_rsp  (i_code_rsp),
   .i_xdata_req (o_xdata_req),
   .i_xdata_rsp (i_xdata_rsp)
);

// File: mcu_ice.sv
`timescale 1ns/10ps

module mcu_ice (
   input  logic       i_clk,
   input  logic       i_nrst,
   input  logic       i_run,
   input  logic       i_prog_we,
   input  logic [5:0] i_prog_addr,
   input  logic [7:0] i_prog_data,
   output logic [4:0] o_led
);

   import mcu_pkg::*;

   prog_wr_t   prog;
   code_req_t  code_req;
   code_rsp_t  code_rsp;
   xdata_req_t xdata_req;
   xdata_rsp_t xdata_rsp;

   // Program load port
   assign prog.we   = i_prog_we;
   assign prog.addr = i_prog_addr;
   assign prog.data = i_prog_data;

   cpu_core u_cpu_core (
      .i_clk       (i_clk),
      .i_nrst      (i_nrst),
      .i_run       (i_run),
      .o_code_req  (code_req),
      .i_code_rsp  (code_rsp),
      .o_xdata_req (xdata_req),
      .i_xdata_rsp (xdata_rsp)
   );

   code_rom u_code_rom (
      .i_clk  (i_clk),
      .i_nrst (i_nrst),
      .i_prog (prog),
      .i_req  (code_req),
      .o_rsp  (code_rsp)
   );

   xdata_ram u_xdata_ram (
      .i_clk  (i_clk),
      .i_nrst (i_nrst),
      .i_req  (xdata_req),
      .o_rsp  (xdata_rsp),
      .o_led  (o_led)
   );

endmodule

// File: cpu_core.sv
`timescale 1ns/10ps

module cpu_core (
   input  logic                i_clk,
   input  logic                i_nrst,
   input  logic                i_run,
   output mcu_pkg::code_req_t  o_code_req,
   input  mcu_pkg::code_rsp_t  i_code_rsp,
   output mcu_pkg::xdata_req_t o_xdata_req,
   input  mcu_pkg::xdata_rsp_t i_xdata_rsp
);

   import mcu_pkg::*;

   typedef enum logic [1:0] {
      IDLE,
      FETCH,
      EXEC,
      XWAIT
   } state_t;

   state_t      state_q;
   logic [15:0] pc_q;
   logic [7:0]  acc_q;
   logic [15:0] dptr_q;
   logic        code_stb_q;
   logic        xd_stb_q;
   logic [31:0] win_q;

   logic [7:0]  op;
   logic [7:0]  opr1;
   logic [7:0]  opr2;
   logic [15:0] rel_ext;
   logic [15:0] next_pc;
   logic        is_movx;
   logic        exec_go;

   logic [7:0]  iram_rd_data;
   logic        iram_wr;
   logic        iram_bit_wr;
   bit_addr_u   bit_addr;

   ////////////////////////////////////////
   // Decode from the fetched window

   assign op   = win_q[7:0];
   assign opr1 = win_q[15:8];
   assign opr2 = win_q[23:16];

   // SJMP offset, sign extended
   assign rel_ext = {{8{opr1[7]}}, opr1};

   assign is_movx = (op == OP_MOVX_WR) || (op == OP_MOVX_RD);
   assign exec_go = (state_q == EXEC) && i_run;

   // Address of the next instruction
   always_comb begin
      case (op)
         OP_MOV_DPTR: begin
            next_pc = pc_q + 16'd3;
         end
         OP_MOV_DIR_A, OP_MOV_A_DIR, OP_SETB, OP_CLR: begin
            next_pc = pc_q + 16'd2;
         end
         OP_SJMP: begin
            next_pc = pc_q + 16'd2 + rel_ext;
         end
         default: begin
            // One-byte opcodes, unknown ones included
            next_pc = pc_q + 16'd1;
         end
      endcase
   end

   ////////////////////////////////////////
   // State machine

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state_q    <= IDLE;
         pc_q       <= 16'h0000;
         acc_q      <= 8'h00;
         dptr_q     <= 16'h0000;
         code_stb_q <= 1'b0;
         xd_stb_q   <= 1'b0;
      end else if (!i_run) begin
         // Held at the reset vector until run
         state_q    <= IDLE;
         pc_q       <= 16'h0000;
         acc_q      <= 8'h00;
         dptr_q     <= 16'h0000;
         code_stb_q <= 1'b0;
         xd_stb_q   <= 1'b0;
      end else begin
         case (state_q)
            IDLE: begin
               code_stb_q <= 1'b1;
               state_q    <= FETCH;
            end
            FETCH: begin
               if (i_code_rsp.ack) begin
                  code_stb_q <= 1'b0;
                  state_q    <= EXEC;
               end
            end
            EXEC: begin
               case (op)
                  OP_INC_A:     acc_q  <= acc_q + 8'd1;
                  OP_MOV_DPTR:  dptr_q <= {opr1, opr2};
                  OP_MOV_A_DIR: acc_q  <= iram_rd_data;
                  default:      acc_q  <= acc_q;
               endcase
               if (is_movx) begin
                  xd_stb_q <= 1'b1;
                  state_q  <= XWAIT;
               end else begin
                  pc_q       <= next_pc;
                  code_stb_q <= 1'b1;
                  state_q    <= FETCH;
               end
            end
            XWAIT: begin
               if (i_xdata_rsp.ack) begin
                  if (op == OP_MOVX_RD) begin
                     acc_q <= i_xdata_rsp.rdata;
                  end
                  xd_stb_q   <= 1'b0;
                  pc_q       <= pc_q + 16'd1;
                  code_stb_q <= 1'b1;
                  state_q    <= FETCH;
               end
            end
            default: begin
               state_q <= IDLE;
            end
         endcase
      end
   end

   // Instruction window
   always_ff @(posedge i_clk) begin
      if (state_q == FETCH && i_code_rsp.ack) begin
         win_q <= i_code_rsp.data;
      end
   end

   ////////////////////////////////////////
   // Bus requests

   // Withdrawn as soon as run drops
   assign o_code_req.stb = code_stb_q & i_run;
   assign o_code_req.addr = pc_q;

   assign o_xdata_req.stb   = xd_stb_q & i_run;
   assign o_xdata_req.we    = xd_stb_q & (op == OP_MOVX_WR);
   assign o_xdata_req.addr  = dptr_q;
   assign o_xdata_req.wdata = acc_q;

   ////////////////////////////////////////
   // Internal RAM

   assign iram_wr       = exec_go && (op == OP_MOV_DIR_A);
   assign iram_bit_wr   = exec_go && ((op == OP_SETB) || (op == OP_CLR));
   assign bit_addr.raw  = opr1;

   iram u_iram (
      .i_clk      (i_clk),
      .i_nrst     (i_nrst),
      .i_rd_addr  (opr1),
      .o_rd_data  (iram_rd_data),
      .i_wr       (iram_wr),
      .i_wr_addr  (opr1),
      .i_wr_data  (acc_q),
      .i_bit_addr (bit_addr),
      .i_bit_wr   (iram_bit_wr),
      .i_bit_val  (op == OP_SETB)
   );

endmodule

// File: iram.sv
`timescale 1ns/10ps

module iram (
   input  logic               i_clk,
   input  logic               i_nrst,
   input  logic [7:0]         i_rd_addr,
   output logic [7:0]         o_rd_data,
   input  logic               i_wr,
   input  logic [7:0]         i_wr_addr,
   input  logic [7:0]         i_wr_data,
   input  mcu_pkg::bit_addr_u i_bit_addr,
   input  logic               i_bit_wr,
   input  logic               i_bit_val
);

   import mcu_pkg::*;

   logic [7:0]         mem [0:IRAM_BYTES-1];
   logic [IRAM_AW-1:0] rd_idx;
   logic [IRAM_AW-1:0] wr_idx;
   logic [IRAM_AW-1:0] bit_byte;
   logic [2:0]         bit_pos;
   logic               bit_in_ram;

   assign rd_idx = i_rd_addr[IRAM_AW-1:0];
   assign wr_idx = i_wr_addr[IRAM_AW-1:0];

   // Upper half is SFR space, which is not present
   assign o_rd_data = i_rd_addr[7] ? 8'h00 : mem[rd_idx];

   ////////////////////////////////////////
   // Bit address decode

   // Bit view: bytes 0x20..0x2F, one bit each
   assign bit_byte   = BIT_AREA_BASE[IRAM_AW-1:0] + IRAM_AW'(i_bit_addr.bits.byte_idx);
   assign bit_pos    = i_bit_addr.bits.bit_idx;
   // Area flag set means an SFR bit, ignored here
   assign bit_in_ram = !i_bit_addr.bits.area;

   ////////////////////////////////////////
   // Write port

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         for (int i = 0; i < IRAM_BYTES; i++) begin
            mem[i] <= 8'h00;
         end
      end else if (i_wr) begin
         // Byte writes win over bit writes
         if (!i_wr_addr[7]) begin
            mem[wr_idx] <= i_wr_data;
         end
      end else if (i_bit_wr && bit_in_ram) begin
         // Read-modify-write of one bit in the target byte
         mem[bit_byte][bit_pos] <= i_bit_val;
      end
   end

endmodule

// File: xdata_ram.sv
`timescale 1ns/10ps

module xdata_ram (
   input  logic                i_clk,
   input  logic                i_nrst,
   input  mcu_pkg::xdata_req_t i_req,
   output mcu_pkg::xdata_rsp_t o_rsp,
   output logic [4:0]          o_led
);

   import mcu_pkg::*;

   logic [7:0]          mem [0:XDATA_BYTES-1];
   logic [XDATA_AW-1:0] idx;
   logic                ack_q;
   logic [7:0]          rdata_q;

   // Only the low address bits decode, upper ones alias
   assign idx = i_req.addr[XDATA_AW-1:0];

   // Byte 0 feeds the LEDs, so it must come up zero
   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         for (int i = 0; i < XDATA_BYTES; i++) begin
            mem[i] <= 8'h00;
         end
      end else if (i_req.stb && i_req.we) begin
         mem[idx] <= i_req.wdata;
      end
   end

   // Read data is zero outside an acknowledged read
   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         ack_q   <= 1'b0;
         rdata_q <= 8'h00;
      end else begin
         ack_q <= i_req.stb;
         if (i_req.stb && !i_req.we) begin
            rdata_q <= mem[idx];
         end else begin
            rdata_q <= 8'h00;
         end
      end
   end

   assign o_rsp.ack   = ack_q;
   assign o_rsp.rdata = rdata_q;

   // LED bank
   assign o_led = mem[0][4:0];

endmodule

// File: code_rom.sv
`timescale 1ns/10ps

module code_rom (
   input  logic               i_clk,
   input  logic               i_nrst,
   input  mcu_pkg::prog_wr_t  i_prog,
   input  mcu_pkg::code_req_t i_req,
   output mcu_pkg::code_rsp_t o_rsp
);

   import mcu_pkg::*;

   logic [7:0]         mem [0:CODE_BYTES-1];
   logic [CODE_AW-1:0] addr0;
   logic [CODE_AW-1:0] addr1;
   logic [CODE_AW-1:0] addr2;
   logic [CODE_AW-1:0] addr3;
   logic               ack_q;
   logic [31:0]        data_q;

   // Window addresses wrap around the end of the ROM
   assign addr0 = i_req.addr[CODE_AW-1:0];
   assign addr1 = addr0 + CODE_AW'(1);
   assign addr2 = addr0 + CODE_AW'(2);
   assign addr3 = addr0 + CODE_AW'(3);

   // Byte load port, empty ROM reads as NOP
   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         for (int i = 0; i < CODE_BYTES; i++) begin
            mem[i] <= OP_NOP;
         end
      end else if (i_prog.we) begin
         mem[i_prog.addr] <= i_prog.data;
      end
   end

   // Acknowledge follows the strobe by one cycle
   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= i_req.stb;
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_req.stb) begin
         data_q <= {mem[addr3], mem[addr2], mem[addr1], mem[addr0]};
      end
   end

   assign o_rsp.ack  = ack_q;
   assign o_rsp.data = data_q;

endmodule

// File: mcu_pkg.sv
package mcu_pkg;

   ////////////////////////////////////////
   // Memory sizes

   localparam int CODE_BYTES  = 64;
   localparam int CODE_AW     = 6;
   localparam int XDATA_BYTES = 16;
   localparam int XDATA_AW    = 4;
   localparam int IRAM_BYTES  = 128;
   localparam int IRAM_AW     = 7;

   // First byte of the bit-addressable area
   localparam logic [7:0] BIT_AREA_BASE = 8'h20;

   ////////////////////////////////////////
   // Opcodes of the supported subset

   localparam logic [7:0] OP_NOP       = 8'h00;
   localparam logic [7:0] OP_INC_A     = 8'h04;
   localparam logic [7:0] OP_MOV_DPTR  = 8'h90;
   localparam logic [7:0] OP_MOVX_WR   = 8'hF0;
   localparam logic [7:0] OP_MOVX_RD   = 8'hE0;
   localparam logic [7:0] OP_MOV_DIR_A = 8'hF5;
   localparam logic [7:0] OP_MOV_A_DIR = 8'hE5;
   localparam logic [7:0] OP_SETB      = 8'hD2;
   localparam logic [7:0] OP_CLR       = 8'hC2;
   localparam logic [7:0] OP_SJMP      = 8'h80;

   ////////////////////////////////////////
   // Bus types

   typedef struct packed {
      logic        stb;
      logic [15:0] addr;
   } code_req_t;

   // Four code bytes, lowest address in the low byte
   typedef struct packed {
      logic        ack;
      logic [31:0] data;
   } code_rsp_t;

   typedef struct packed {
      logic        stb;
      logic        we;
      logic [15:0] addr;
      logic [7:0]  wdata;
   } xdata_req_t;

   typedef struct packed {
      logic       ack;
      logic [7:0] rdata;
   } xdata_rsp_t;

   // Operand byte of SETB/CLR, seen raw or as area/byte/bit fields
   typedef union packed {
      logic [7:0] raw;
      struct packed {
         logic       area;
         logic [3:0] byte_idx;
         logic [2:0] bit_idx;
      } bits;
   } bit_addr_u;

   typedef struct packed {
      logic               we;
      logic [CODE_AW-1:0] addr;
      logic [7:0]         data;
   } prog_wr_t;

endpackage
